/* logic/proc_pkg.sv */
package proc_pkg;

    // data and byte address width
    localparam int XLEN       = 16;
    localparam int REG_ADDR_W = 3;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;
    localparam int MEM_WORDS  = 256;
    localparam int MEM_IDX_W  = $clog2(MEM_WORDS);

    // jal writes its return address here
    localparam logic [REG_ADDR_W-1:0] LINK_REG = 3'd7;

    // instruction opcodes, bits 15:11
    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_J     = 5'b00100,
        OP_JR    = 5'b00101,
        OP_JAL   = 5'b00110,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_BLTZ  = 5'b01110,
        OP_BGEZ  = 5'b01111,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_SLBI  = 5'b10010,
        OP_LBI   = 5'b11000,
        OP_SHIFT = 5'b11010,
        OP_ARITH = 5'b11011,
        OP_SEQ   = 5'b11100,
        OP_SLT   = 5'b11101,
        OP_SLE   = 5'b11110,
        OP_SCO   = 5'b11111
    } opcode_e;

    // function field, bits 1:0; in the shift group the last code is reserved
    typedef enum logic [1:0] {
        FN_ADD_SLL  = 2'b00,
        FN_SUB_SRL  = 2'b01,
        FN_XOR_ROL  = 2'b10,
        FN_ANDN_RSV = 2'b11
    } alu_fn_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN,
        ALU_SLL, ALU_SRL, ALU_ROL,
        ALU_SEQ, ALU_SLT, ALU_SLE, ALU_SCO,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {IMM_Z5, IMM_S5, IMM_S8, IMM_S11, IMM_SLBI} imm_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC_PLUS, WB_IMM} wb_sel_e;
    typedef enum logic [1:0] {DST_RD, DST_RT, DST_RS, DST_LINK} dest_sel_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'b000,
        BR_EQZ  = 3'b100,
        BR_NEZ  = 3'b101,
        BR_LTZ  = 3'b110,
        BR_GEZ  = 3'b111
    } branch_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      alu_src_imm;
        imm_sel_e  imm_sel;
        wb_sel_e   wb_sel;
        logic      reg_write;
        dest_sel_e dest_sel;
        logic      mem_read;
        logic      mem_write;
        branch_e   branch;
        logic      jump;
        logic      jump_reg;
        logic      halt;
        logic      illegal;
    } ctrl_t;

    // register write performed at the coming edge
    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } wb_trace_t;

endpackage

/* logic/proc_control.sv */
`timescale 1ns/10ps

module proc_control (
    input  logic [proc_pkg::XLEN-1:0] i_instr,
    output proc_pkg::ctrl_t           o_ctrl
);
    import proc_pkg::*;

    opcode_e opcode;
    alu_fn_e fn;

    // shared by the register and immediate arithmetic groups
    function automatic alu_op_e arith_op(input alu_fn_e f);
        case (f)
            FN_ADD_SLL: arith_op = ALU_ADD;
            FN_SUB_SRL: arith_op = ALU_SUB;
            FN_XOR_ROL: arith_op = ALU_XOR;
            default:    arith_op = ALU_ANDN;
        endcase
    endfunction

    assign opcode = opcode_e'(i_instr[XLEN-1:XLEN-5]);
    assign fn     = alu_fn_e'(i_instr[1:0]);

    //////////////////////////////
    // decode
    //////////////////////////////
    always_comb begin
        o_ctrl          = '0;
        o_ctrl.alu_op   = ALU_PASS_B;
        o_ctrl.imm_sel  = IMM_S5;
        o_ctrl.wb_sel   = WB_ALU;
        o_ctrl.dest_sel = DST_RD;
        o_ctrl.branch   = BR_NONE;
        case (opcode)
            OP_HALT: o_ctrl.halt = 1'b1;
            OP_NOP: begin
            end
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
                // low opcode bits carry the same code as the function field
                o_ctrl.alu_op      = arith_op(alu_fn_e'(i_instr[12:11]));
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.imm_sel     = (opcode inside {OP_XORI, OP_ANDNI}) ? IMM_Z5 : IMM_S5;
                o_ctrl.dest_sel    = DST_RT;
                o_ctrl.reg_write   = 1'b1;
            end
            OP_ARITH: begin
                o_ctrl.alu_op    = arith_op(fn);
                o_ctrl.reg_write = 1'b1;
            end
            OP_SHIFT: begin
                case (fn)
                    FN_ADD_SLL: o_ctrl.alu_op = ALU_SLL;
                    FN_SUB_SRL: o_ctrl.alu_op = ALU_SRL;
                    FN_XOR_ROL: o_ctrl.alu_op = ALU_ROL;
                    default:    o_ctrl.illegal = 1'b1;
                endcase
                o_ctrl.reg_write = !o_ctrl.illegal;
            end
            OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
                case (opcode)
                    OP_SEQ:  o_ctrl.alu_op = ALU_SEQ;
                    OP_SLT:  o_ctrl.alu_op = ALU_SLT;
                    OP_SLE:  o_ctrl.alu_op = ALU_SLE;
                    default: o_ctrl.alu_op = ALU_SCO;
                endcase
                o_ctrl.reg_write = 1'b1;
            end
            OP_LD, OP_ST: begin
                // address is rs plus the signed 5-bit offset
                o_ctrl.alu_op      = ALU_ADD;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.dest_sel    = DST_RT;
                o_ctrl.wb_sel      = WB_MEM;
                o_ctrl.mem_read    = (opcode == OP_LD);
                o_ctrl.mem_write   = (opcode == OP_ST);
                o_ctrl.reg_write   = (opcode == OP_LD);
            end
            OP_LBI, OP_SLBI: begin
                o_ctrl.imm_sel   = (opcode == OP_LBI) ? IMM_S8 : IMM_SLBI;
                o_ctrl.wb_sel    = WB_IMM;
                o_ctrl.dest_sel  = DST_RS;
                o_ctrl.reg_write = 1'b1;
            end
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
                o_ctrl.imm_sel = IMM_S8;
                case (opcode)
                    OP_BEQZ: o_ctrl.branch = BR_EQZ;
                    OP_BNEZ: o_ctrl.branch = BR_NEZ;
                    OP_BLTZ: o_ctrl.branch = BR_LTZ;
                    default: o_ctrl.branch = BR_GEZ;
                endcase
            end
            OP_J, OP_JAL: begin
                o_ctrl.imm_sel   = IMM_S11;
                o_ctrl.jump      = 1'b1;
                o_ctrl.reg_write = (opcode == OP_JAL);
                o_ctrl.dest_sel  = DST_LINK;
                o_ctrl.wb_sel    = WB_PC_PLUS;
            end
            OP_JR: begin
                o_ctrl.imm_sel  = IMM_S8;
                o_ctrl.jump_reg = 1'b1;
            end
            default: o_ctrl.illegal = 1'b1;
        endcase
    end

    always_comb begin
        assert (!(o_ctrl.mem_write && o_ctrl.reg_write))
            else $error("decoder requests a store and a register write together");
    end

endmodule

/* logic/proc_alu.sv */
`timescale 1ns/10ps

module proc_alu (
    input  logic [proc_pkg::XLEN-1:0] i_a,
    input  logic [proc_pkg::XLEN-1:0] i_b,
    input  proc_pkg::alu_op_e         i_op,
    output logic [proc_pkg::XLEN-1:0] o_result,
    output logic                      o_zero,
    output logic                      o_neg
);
    import proc_pkg::*;

    logic                    subtract;
    logic [XLEN-1:0]         b_opnd;
    logic [XLEN:0]           sum;
    logic                    ovf;
    logic                    lt;
    logic                    eq;
    logic [$clog2(XLEN)-1:0] shamt;
    logic [2*XLEN-1:0]       rot;

    // sub and the compares run a - b through the same adder
    assign subtract = (i_op == ALU_SUB) || (i_op == ALU_SEQ) ||
                      (i_op == ALU_SLT) || (i_op == ALU_SLE);
    assign b_opnd   = subtract ? ~i_b : i_b;
    assign sum      = {1'b0, i_a} + {1'b0, b_opnd} + {{XLEN{1'b0}}, subtract};

    // signed compare from sign and overflow of the difference
    assign ovf = (i_a[XLEN-1] == b_opnd[XLEN-1]) && (sum[XLEN-1] != i_a[XLEN-1]);
    assign lt  = sum[XLEN-1] ^ ovf;
    assign eq  = (sum[XLEN-1:0] == '0);

    assign shamt = i_b[$clog2(XLEN)-1:0];
    // upper half of the doubled word is the rotate
    assign rot   = {i_a, i_a} << shamt;

    always_comb begin
        case (i_op)
            ALU_ADD, ALU_SUB: o_result = sum[XLEN-1:0];
            ALU_XOR:          o_result = i_a ^ i_b;
            ALU_ANDN:         o_result = i_a & ~i_b;
            ALU_SLL:          o_result = i_a << shamt;
            ALU_SRL:          o_result = i_a >> shamt;
            ALU_ROL:          o_result = rot[2*XLEN-1:XLEN];
            ALU_SEQ:          o_result = {{(XLEN-1){1'b0}}, eq};
            ALU_SLT:          o_result = {{(XLEN-1){1'b0}}, lt};
            ALU_SLE:          o_result = {{(XLEN-1){1'b0}}, lt | eq};
            // carry out of a + b
            ALU_SCO:          o_result = {{(XLEN-1){1'b0}}, sum[XLEN]};
            ALU_PASS_B:       o_result = i_b;
            default:          o_result = i_b;
        endcase
    end

    assign o_zero = (o_result == '0);
    assign o_neg  = o_result[XLEN-1];

endmodule

/* logic/proc_regfile.sv */
`timescale 1ns/10ps

module proc_regfile (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic [proc_pkg::REG_ADDR_W-1:0] i_rs_addr,
    input  logic [proc_pkg::REG_ADDR_W-1:0] i_rt_addr,
    input  logic                            i_wr_en,
    input  logic [proc_pkg::REG_ADDR_W-1:0] i_wr_addr,
    input  logic [proc_pkg::XLEN-1:0]       i_wr_data,
    output logic [proc_pkg::XLEN-1:0]       o_rs_data,
    output logic [proc_pkg::XLEN-1:0]       o_rt_data
);
    import proc_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // no bypass, a same-cycle write shows up after the edge
    assign o_rs_data = regs[i_rs_addr];
    assign o_rt_data = regs[i_rt_addr];

    a_wr_data_known: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_wr_en |-> !$isunknown({i_wr_addr, i_wr_data}))
        else $error("register write with unknown address or data");

endmodule

/* logic/proc_mem.sv */
`timescale 1ns/10ps

module proc_mem (
    input  logic                      clk,
    input  logic [proc_pkg::XLEN-1:0] i_addr,
    input  logic                      i_wr_en,
    input  logic [proc_pkg::XLEN-1:0] i_wr_data,
    output logic [proc_pkg::XLEN-1:0] o_rd_data
);
    import proc_pkg::*;

    logic [XLEN-1:0]      mem [MEM_WORDS];
    logic [MEM_IDX_W-1:0] idx;

    // byte address to word index, upper bits wrap
    assign idx = i_addr[MEM_IDX_W:1];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[idx] <= i_wr_data;
        end
    end

    assign o_rd_data = mem[idx];

endmodule

/* logic/proc_next_pc.sv */
`timescale 1ns/10ps

module proc_next_pc (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_hold,
    input  logic                      i_restart,
    input  proc_pkg::ctrl_t           i_ctrl,
    input  logic [proc_pkg::XLEN-1:0] i_rs_data,
    input  logic [proc_pkg::XLEN-1:0] i_imm,
    output logic [proc_pkg::XLEN-1:0] o_pc,
    output logic [proc_pkg::XLEN-1:0] o_pc_plus
);
    import proc_pkg::*;

    logic [XLEN-1:0] target;
    logic [XLEN-1:0] pc_next;
    logic            taken;

    assign o_pc_plus = o_pc + XLEN'(2);
    // jr is register relative, everything else pc+2 relative
    assign target    = (i_ctrl.jump_reg ? i_rs_data : o_pc_plus) + i_imm;

    // branch test on rs alone
    always_comb begin
        case (i_ctrl.branch)
            BR_EQZ:  taken = (i_rs_data == '0);
            BR_NEZ:  taken = (i_rs_data != '0);
            BR_LTZ:  taken = i_rs_data[XLEN-1];
            BR_GEZ:  taken = !i_rs_data[XLEN-1];
            default: taken = 1'b0;
        endcase
    end

    assign pc_next = (taken || i_ctrl.jump || i_ctrl.jump_reg) ? target : o_pc_plus;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc <= '0;
        end else if (i_restart) begin
            o_pc <= '0;
        end else if (!i_hold) begin
            o_pc <= pc_next;
        end
    end

endmodule

/* logic/proc_top.sv */
`timescale 1ns/10ps

module proc_top (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_load_en,
    input  logic [proc_pkg::XLEN-1:0] i_load_addr,
    input  logic [proc_pkg::XLEN-1:0] i_load_data,
    output logic [proc_pkg::XLEN-1:0] o_pc,
    output proc_pkg::wb_trace_t       o_wb,
    output logic                      o_halt,
    output logic                      o_err
);
    import proc_pkg::*;

    ctrl_t                 ctrl;
    logic [XLEN-1:0]       imem_addr;
    logic [XLEN-1:0]       instr;
    logic [XLEN-1:0]       pc_plus;
    logic [XLEN-1:0]       rs_data;
    logic [XLEN-1:0]       rt_data;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       alu_b;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       dmem_rdata;
    logic [XLEN-1:0]       load_data;
    logic [XLEN-1:0]       wb_data;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic                  run;
    logic                  wr_en;
    logic                  dmem_wr_en;
    logic                  hold;
    logic                  halted_q;
    logic                  err_q;

    //////////////////////////////
    // fetch and decode
    //////////////////////////////
    // load port takes over the instruction memory
    assign imem_addr = i_load_en ? i_load_addr : o_pc;

    proc_mem inst_mem (
        .clk       (clk),
        .i_addr    (imem_addr),
        .i_wr_en   (i_load_en),
        .i_wr_data (i_load_data),
        .o_rd_data (instr)
    );

    proc_control ctrl_dec (
        .i_instr (instr),
        .o_ctrl  (ctrl)
    );

    proc_regfile reg_file (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_rs_addr (instr[10:8]),
        .i_rt_addr (instr[7:5]),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wb_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    // immediate formats
    always_comb begin
        case (ctrl.imm_sel)
            IMM_Z5:   imm = {{(XLEN-5){1'b0}}, instr[4:0]};
            IMM_S5:   imm = {{(XLEN-5){instr[4]}}, instr[4:0]};
            IMM_S8:   imm = {{(XLEN-8){instr[7]}}, instr[7:0]};
            IMM_S11:  imm = {{(XLEN-11){instr[10]}}, instr[10:0]};
            // slbi: old low byte moves up, new byte below it
            IMM_SLBI: imm = {rs_data[7:0], instr[7:0]};
            default:  imm = {rs_data[7:0], instr[7:0]};
        endcase
    end

    //////////////////////////////
    // execute and memory
    //////////////////////////////
    assign alu_b = ctrl.alu_src_imm ? imm : rt_data;

    proc_alu main_alu (
        .i_a      (rs_data),
        .i_b      (alu_b),
        .i_op     (ctrl.alu_op),
        .o_result (alu_result),
        .o_zero   (),
        .o_neg    ()
    );

    proc_mem data_mem (
        .clk       (clk),
        .i_addr    (alu_result),
        .i_wr_en   (dmem_wr_en),
        .i_wr_data (rt_data),
        .o_rd_data (dmem_rdata)
    );

    assign load_data = ctrl.mem_read ? dmem_rdata : '0;

    //////////////////////////////
    // write-back
    //////////////////////////////
    always_comb begin
        case (ctrl.dest_sel)
            DST_RD:  wr_addr = instr[4:2];
            DST_RT:  wr_addr = instr[7:5];
            DST_RS:  wr_addr = instr[10:8];
            default: wr_addr = LINK_REG;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            WB_ALU:     wb_data = alu_result;
            WB_MEM:     wb_data = load_data;
            WB_PC_PLUS: wb_data = pc_plus;
            default:    wb_data = imm;
        endcase
    end

    // no state changes while loading or once halted
    assign run        = !i_load_en && !halted_q;
    assign wr_en      = ctrl.reg_write && run;
    assign dmem_wr_en = ctrl.mem_write && run;
    assign o_wb       = '{en: wr_en, addr: wr_addr, data: wb_data};

    //////////////////////////////
    // pc, halt and error
    //////////////////////////////
    // pc stays on the halt or illegal word
    assign hold = halted_q || ctrl.halt || ctrl.illegal;

    proc_next_pc pc_unit (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_hold    (hold),
        .i_restart (i_load_en),
        .i_ctrl    (ctrl),
        .i_rs_data (rs_data),
        .i_imm     (imm),
        .o_pc      (o_pc),
        .o_pc_plus (pc_plus)
    );

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            halted_q <= 1'b0;
            err_q    <= 1'b0;
        end else if (run) begin
            if (ctrl.halt || ctrl.illegal) begin
                halted_q <= 1'b1;
            end
            if (ctrl.illegal) begin
                err_q <= 1'b1;
            end
        end
    end

    assign o_halt = halted_q;
    assign o_err  = err_q;

    a_halt_pc_frozen: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_halt && !i_load_en) |=> $stable(o_pc))
        else $error("pc moved after halt");

endmodule

/* bench/proc_tb.sv */
`timescale 1ns/10ps

module proc_tb;
    import proc_pkg::*;

    localparam int RESET_CYCLES  = 5;
    localparam int SETTLE_CYCLES = 6;
    localparam int RANDOM_OPS    = 24;
    localparam int MEM_PAIRS     = 4;

    logic            clk = 1'b0;
    logic            i_rst_n;
    logic            i_load_en;
    logic [XLEN-1:0] i_load_addr;
    logic [XLEN-1:0] i_load_data;
    logic [XLEN-1:0] o_pc;
    wb_trace_t       o_wb;
    logic            o_halt;
    logic            o_err;

    // program words and the test each word belongs to
    logic [XLEN-1:0] words [$];
    string           tags [$];
    logic [31:0]     rng = 32'd43639;
    int              watchdog_cycles = 0;
    int              main_len;

    // reference model state
    logic [XLEN-1:0]       imem_model [MEM_WORDS];
    string                 imem_tag [MEM_WORDS];
    logic [XLEN-1:0]       m_pc;
    logic [XLEN-1:0]       m_regs [NUM_REGS];
    logic [XLEN-1:0]       m_dmem [MEM_WORDS];
    logic                  m_halt;
    logic                  m_err;
    logic [XLEN-1:0]       m_instr;
    logic [XLEN-1:0]       m_rs;
    logic [XLEN-1:0]       m_rt;
    logic [XLEN-1:0]       m_res;
    logic [XLEN-1:0]       m_addr;
    logic [XLEN-1:0]       m_npc;
    logic [REG_ADDR_W-1:0] m_dst;
    logic                  m_wen;
    logic                  m_sten;
    logic                  m_stop;
    logic                  m_bad;
    wb_trace_t             exp_wb;

    proc_top i_dut (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_load_en   (i_load_en),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .o_pc        (o_pc),
        .o_wb        (o_wb),
        .o_halt      (o_halt),
        .o_err       (o_err)
    );

    always #20 clk = ~clk;

    //////////////////////////////
    // helpers
    //////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_random(output logic [31:0] v);
        rng = xorshift(rng);
        v = rng;
    endtask

    // sign-extend the low bits of a word
    function automatic logic [XLEN-1:0] low_signed(input logic [XLEN-1:0] w, input int bits);
        logic [XLEN-1:0] mask;
        mask = {XLEN{1'b1}} << bits;
        return w[bits-1] ? (w | mask) : (w & ~mask);
    endfunction

    function automatic logic [XLEN-1:0] r_format(input logic [4:0] op, input logic [2:0] rs,
                                                 input logic [2:0] rt, input logic [2:0] rd,
                                                 input logic [1:0] fn);
        return {op, rs, rt, rd, fn};
    endfunction

    function automatic logic [XLEN-1:0] i_format(input logic [4:0] op, input logic [2:0] rs,
                                                 input logic [2:0] rt, input logic [4:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [XLEN-1:0] b_format(input logic [4:0] op, input logic [2:0] rs,
                                                 input logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    function automatic logic [XLEN-1:0] j_format(input logic [4:0] op, input logic [10:0] imm);
        return {op, imm};
    endfunction

    task automatic emit(input logic [XLEN-1:0] w, input string tag);
        words.push_back(w);
        tags.push_back(tag);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string what, input logic [XLEN-1:0] pc,
                                   input logic [31:0] expected, input logic [31:0] actual);
        abort_run($sformatf("MISMATCH test=%s signal=%s pc=%h expected=%h actual=%h",
                            imem_tag[pc[MEM_IDX_W:1]], what, pc, expected, actual));
    endtask

    //////////////////////////////
    // ISA reference model
    //////////////////////////////
    function automatic logic [XLEN-1:0] arith_ref(input logic [1:0] fn,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (fn)
            2'd0:    return a + b;
            2'd1:    return a - b;
            2'd2:    return a ^ b;
            default: return a & ~b;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] shift_ref(input logic [1:0] fn,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [3:0] n);
        case (fn)
            2'd0:    return a << n;
            2'd1:    return a >> n;
            default: return (a << n) | (a >> (XLEN - int'(n)));
        endcase
    endfunction

    function automatic logic set_ref(input logic [1:0] kind, input logic [XLEN-1:0] a,
                                     input logic [XLEN-1:0] b);
        logic [XLEN:0] wide;
        wide = {1'b0, a} + {1'b0, b};
        case (kind)
            2'd0:    return a == b;
            2'd1:    return $signed(a) < $signed(b);
            2'd2:    return $signed(a) <= $signed(b);
            default: return wide[XLEN];
        endcase
    endfunction

    always_comb begin
        m_instr = imem_model[m_pc[MEM_IDX_W:1]];
        m_rs    = m_regs[m_instr[10:8]];
        m_rt    = m_regs[m_instr[7:5]];
        m_addr  = m_rs + low_signed(m_instr, 5);
        m_res   = '0;
        m_dst   = m_instr[4:2];
        m_wen   = 1'b0;
        m_sten  = 1'b0;
        m_stop  = 1'b0;
        m_bad   = 1'b0;
        m_npc   = m_pc + 16'd2;
        case (m_instr[15:11])
            OP_HALT: m_stop = 1'b1;
            OP_NOP: begin
            end
            OP_ARITH: begin
                m_wen = 1'b1;
                m_res = arith_ref(m_instr[1:0], m_rs, m_rt);
            end
            OP_SHIFT: begin
                m_bad = (m_instr[1:0] == 2'b11);
                m_wen = !m_bad;
                m_res = shift_ref(m_instr[1:0], m_rs, m_rt[3:0]);
            end
            OP_ADDI, OP_SUBI: begin
                m_wen = 1'b1;
                m_dst = m_instr[7:5];
                m_res = arith_ref(m_instr[12:11], m_rs, low_signed(m_instr, 5));
            end
            OP_XORI, OP_ANDNI: begin
                m_wen = 1'b1;
                m_dst = m_instr[7:5];
                m_res = arith_ref(m_instr[12:11], m_rs, m_instr & 16'h001f);
            end
            OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
                m_wen = 1'b1;
                m_res = {{(XLEN-1){1'b0}}, set_ref(m_instr[12:11], m_rs, m_rt)};
            end
            OP_LBI: begin
                m_wen = 1'b1;
                m_dst = m_instr[10:8];
                m_res = low_signed(m_instr, 8);
            end
            OP_SLBI: begin
                m_wen = 1'b1;
                m_dst = m_instr[10:8];
                m_res = (m_rs << 8) | (m_instr & 16'h00ff);
            end
            OP_LD: begin
                m_wen = 1'b1;
                m_dst = m_instr[7:5];
                m_res = m_dmem[m_addr[MEM_IDX_W:1]];
            end
            OP_ST: m_sten = 1'b1;
            OP_BEQZ: if (m_rs == '0) m_npc = m_pc + 16'd2 + low_signed(m_instr, 8);
            OP_BNEZ: if (m_rs != '0) m_npc = m_pc + 16'd2 + low_signed(m_instr, 8);
            OP_BLTZ: if (m_rs[XLEN-1]) m_npc = m_pc + 16'd2 + low_signed(m_instr, 8);
            OP_BGEZ: if (!m_rs[XLEN-1]) m_npc = m_pc + 16'd2 + low_signed(m_instr, 8);
            OP_J: m_npc = m_pc + 16'd2 + low_signed(m_instr, 11);
            OP_JAL: begin
                m_npc = m_pc + 16'd2 + low_signed(m_instr, 11);
                m_wen = 1'b1;
                m_dst = LINK_REG;
                m_res = m_pc + 16'd2;
            end
            OP_JR: m_npc = m_rs + low_signed(m_instr, 8);
            default: m_bad = 1'b1;
        endcase
        if (m_stop || m_bad) begin
            m_npc = m_pc;
        end
        exp_wb = '{en: m_wen && !i_load_en && !m_halt, addr: m_dst, data: m_res};
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            m_pc   <= '0;
            m_halt <= 1'b0;
            m_err  <= 1'b0;
            for (int i = 0; i < NUM_REGS; i++) begin
                m_regs[i] <= '0;
            end
        end else if (i_load_en) begin
            m_pc <= '0;
        end else if (!m_halt) begin
            m_pc <= m_npc;
            if (m_wen) begin
                m_regs[m_dst] <= m_res;
            end
            if (m_stop || m_bad) begin
                m_halt <= 1'b1;
            end
            if (m_bad) begin
                m_err <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst_n && !i_load_en && !m_halt && m_sten) begin
            m_dmem[m_addr[MEM_IDX_W:1]] <= m_rt;
        end
    end

    //////////////////////////////
    // checks against the model
    //////////////////////////////
    a_pc_matches: assert property (@(posedge clk) disable iff (!i_rst_n) o_pc == m_pc)
        else report_mismatch("o_pc", $sampled(m_pc), 32'($sampled(m_pc)), 32'($sampled(o_pc)));

    a_wb_matches: assert property (@(posedge clk) disable iff (!i_rst_n)
        exp_wb.en ? (o_wb == exp_wb) : !o_wb.en)
        else report_mismatch("o_wb", $sampled(m_pc), 32'($sampled(exp_wb)),
                             32'($sampled(o_wb)));

    a_halt_matches: assert property (@(posedge clk) disable iff (!i_rst_n) o_halt == m_halt)
        else report_mismatch("o_halt", $sampled(m_pc), 32'($sampled(m_halt)),
                             32'($sampled(o_halt)));

    a_err_matches: assert property (@(posedge clk) disable iff (!i_rst_n) o_err == m_err)
        else report_mismatch("o_err", $sampled(m_pc), 32'($sampled(m_err)),
                             32'($sampled(o_err)));

    //////////////////////////////
    // programs
    //////////////////////////////
    task automatic build_main_program();
        logic [31:0]     w;
        logic [XLEN-1:0] tgt;
        logic [7:0]      v [3];
        int              k;
        // random starting values for r0..r6
        for (int i = 0; i < NUM_REGS - 1; i++) begin
            draw_random(w);
            emit(b_format(OP_LBI, 3'(i), w[15:8]), "lbi/slbi");
            emit(b_format(OP_SLBI, 3'(i), w[7:0]), "lbi/slbi");
        end
        for (int i = 0; i < RANDOM_OPS; i++) begin
            draw_random(w);
            k = int'(w[31:28]);
            if (k < 4) begin
                emit(r_format(OP_ARITH, w[2:0], w[5:3], w[8:6], 2'(k)), "arith");
            end else if (k < 7) begin
                emit(r_format(OP_SHIFT, w[2:0], w[5:3], w[8:6], 2'(k - 4)), "shift");
            end else if (k < 11) begin
                emit(i_format(5'(OP_ADDI) + 5'(k - 7), w[2:0], w[5:3], w[13:9]), "immediate");
            end else if (k < 15) begin
                emit(r_format(5'(OP_SEQ) + 5'(k - 11), w[2:0], w[5:3], w[8:6], 2'd0), "set");
            end else begin
                emit(r_format(OP_NOP, w[2:0], w[5:3], w[8:6], w[10:9]), "nop");
            end
        end
        // each load reads back the word its store just wrote
        for (int i = 0; i < MEM_PAIRS; i++) begin
            draw_random(w);
            emit(i_format(OP_ST, w[2:0], w[5:3], w[13:9]), "load/store");
            emit(i_format(OP_LD, w[2:0], w[8:6], w[13:9]), "load/store");
        end
        draw_random(w);
        v[0] = 8'h00;
        v[1] = {1'b0, w[6:0]} | 8'h01;
        v[2] = {1'b1, w[14:8]};
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 3; j++) begin
                emit(b_format(OP_LBI, 3'd1, v[j]), "branch");
                emit(b_format(5'(OP_BEQZ) + 5'(i), 3'd1, 8'd2), "branch");
                emit(b_format(OP_LBI, 3'd2, 8'h11), "branch");
            end
        end
        emit(j_format(OP_J, 11'd2), "jump");
        emit(b_format(OP_LBI, 3'd3, 8'h22), "jump");
        emit(j_format(OP_JAL, 11'd2), "jump");
        emit(b_format(OP_LBI, 3'd3, 8'h33), "jump");
        // jr with offset -2 lands two words past itself
        tgt = 16'((words.size() + 4) * 2 + 2);
        emit(b_format(OP_LBI, 3'd5, tgt[15:8]), "jump");
        emit(b_format(OP_SLBI, 3'd5, tgt[7:0]), "jump");
        emit(b_format(OP_JR, 3'd5, 8'hfe), "jump");
        emit(b_format(OP_LBI, 3'd3, 8'h44), "jump");
        emit(r_format(OP_ARITH, 3'd7, 3'd5, 3'd4, 2'd0), "jump");
        emit(j_format(OP_HALT, 11'd0), "halt");
    endtask

    task automatic build_fault_program();
        logic [31:0] w;
        logic [4:0]  bad;
        draw_random(w);
        case (w[18:16])
            3'd0:    bad = 5'b00010;
            3'd1:    bad = 5'b00011;
            3'd2:    bad = 5'b00111;
            3'd3:    bad = 5'b10011;
            3'd4:    bad = 5'b10100;
            3'd5:    bad = 5'b10101;
            3'd6:    bad = 5'b10110;
            default: bad = 5'b11001;
        endcase
        emit(b_format(OP_LBI, 3'd1, w[7:0]), "illegal opcode");
        emit(i_format(OP_ADDI, 3'd1, 3'd2, w[12:8]), "illegal opcode");
        emit({bad, w[31:21]}, "illegal opcode");
        emit(i_format(OP_ADDI, 3'd1, 3'd3, 5'd1), "illegal opcode");
        emit(j_format(OP_HALT, 11'd0), "illegal opcode");
    endtask

    // first word goes in on the edge that releases reset
    task automatic load_program(input int first, input int count);
        for (int i = 0; i < count; i++) begin
            imem_model[i] = words[first + i];
            imem_tag[i]   = tags[first + i];
            i_rst_n     <= 1'b1;
            i_load_en   <= 1'b1;
            i_load_addr <= 16'(2 * i);
            i_load_data <= words[first + i];
            @(posedge clk);
        end
        i_load_en <= 1'b0;
    endtask

    task automatic run_until_halt(input logic expect_err);
        wait (o_halt);
        repeat (SETTLE_CYCLES) @(posedge clk);
        if (o_err !== expect_err) begin
            abort_run($sformatf("error flag is %b after the program stopped, wanted %b",
                                o_err, expect_err));
        end
    endtask

    initial begin : stimulus
        i_rst_n     = 1'b0;
        i_load_en   = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        build_main_program();
        main_len = words.size();
        build_fault_program();
        watchdog_cycles = 2 * words.size() + 2 * (RESET_CYCLES + SETTLE_CYCLES) + 50;
        repeat (RESET_CYCLES) @(posedge clk);
        load_program(0, main_len);
        run_until_halt(1'b0);
        // halt is sticky, so the second program needs a reset
        i_rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        load_program(main_len, words.size() - main_len);
        run_until_halt(1'b1);
        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin : watchdog
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        abort_run("timeout: the processor did not finish both programs in time");
    end

endmodule

/* all.f */
logic/proc_pkg.sv
logic/proc_control.sv
logic/proc_alu.sv
logic/proc_regfile.sv
logic/proc_mem.sv
logic/proc_next_pc.sv
logic/proc_top.sv
bench/proc_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the processor testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator is not on the PATH"
    exit 1
fi

verilator --binary --timing --assert --top-module proc_tb -Mdir "$BUILD_DIR" -f all.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vproc_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
